/* build.f */
rtl/muldiv_pkg.sv
rtl/mul_pipe.sv
rtl/div_pipe.sv
rtl/muldiv_ctrl.sv
rtl/muldiv_unit.sv
verification/muldiv_tb.sv
+incdir+verification

/* rtl/div_pipe.sv */
module div_pipe (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   adv,
    input  logic                   go,
    input  muldiv_pkg::issue_req_t s1,
    output logic                   done,
    output muldiv_pkg::wb_t        wb
);

    logic                              is_signed;
    logic                              is_rem;
    logic                              zero_d;
    logic                              zero_w;
    logic                              ovf_d;
    logic                              ovf_w;
    logic [muldiv_pkg::xlen-1:0]       divisor_d;
    logic [muldiv_pkg::word_w-1:0]     divisor_w;
    logic [muldiv_pkg::word_w-1:0]     dividend_w;
    logic [muldiv_pkg::xlen-1:0]       quot_d;
    logic [muldiv_pkg::xlen-1:0]       rem_d;
    logic [muldiv_pkg::word_w-1:0]     quot_w;
    logic [muldiv_pkg::word_w-1:0]     rem_w;
    logic [muldiv_pkg::xlen-1:0]       result;
    muldiv_pkg::wb_t                   wb_q;
    logic                              done_q;

    assign is_signed  = ~muldiv_pkg::op_is_unsigned_div(s1.op);
    assign is_rem     = muldiv_pkg::op_is_rem(s1.op);
    assign dividend_w = s1.src1[muldiv_pkg::word_w-1:0];

    assign zero_d = (s1.src2 == '0);
    assign zero_w = (s1.src2[muldiv_pkg::word_w-1:0] == '0);

    // Most negative value divided by minus one
    assign ovf_d = (s1.src1 == {1'b1, {(muldiv_pkg::xlen-1){1'b0}}}) && (s1.src2 == '1);
    assign ovf_w = (dividend_w == {1'b1, {(muldiv_pkg::word_w-1){1'b0}}})
                && (s1.src2[muldiv_pkg::word_w-1:0] == '1);

    // Dividing by one on overflow yields the dividend and a zero remainder,
    // which is exactly the RISC-V overflow result
    assign divisor_d = (zero_d || (is_signed && ovf_d)) ? 1 : s1.src2;
    assign divisor_w = (zero_w || (is_signed && ovf_w)) ? 1
                                                        : s1.src2[muldiv_pkg::word_w-1:0];

    always_comb begin
        if (is_signed) begin
            quot_d = $signed(s1.src1) / $signed(divisor_d);
            rem_d  = $signed(s1.src1) % $signed(divisor_d);
            quot_w = $signed(dividend_w) / $signed(divisor_w);
            rem_w  = $signed(dividend_w) % $signed(divisor_w);
        end else begin
            quot_d = s1.src1 / divisor_d;
            rem_d  = s1.src1 % divisor_d;
            quot_w = dividend_w / divisor_w;
            rem_w  = dividend_w % divisor_w;
        end
        if (zero_d) begin
            quot_d = '1;
            rem_d  = s1.src1;
        end
        if (zero_w) begin
            quot_w = '1;
            rem_w  = dividend_w;
        end
    end

    always_comb begin
        if (s1.is_w) begin
            result = muldiv_pkg::sext_word(is_rem ? rem_w : quot_w);
        end else begin
            result = is_rem ? rem_d : quot_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else if (adv) begin
            done_q <= go;
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            wb_q.result <= result;
            wb_q.nxtpc  <= s1.nxtpc;
            wb_q.rd     <= s1.rd;
            wb_q.error  <= s1.error | (s1.is_w ? zero_w : zero_d); // Divide by zero traps
        end
    end

    assign done = done_q;
    assign wb   = wb_q;

endmodule

/* rtl/mul_pipe.sv */
module mul_pipe (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   adv,
    input  logic                   go,
    input  muldiv_pkg::issue_req_t s1,
    output logic                   done,
    output muldiv_pkg::wb_t        wb
);

    logic                            a_signed;
    logic                            b_signed;
    logic [2*muldiv_pkg::xlen-1:0]   a_ext;
    logic [2*muldiv_pkg::xlen-1:0]   b_ext;
    logic [2*muldiv_pkg::xlen-1:0]   prod;
    logic [muldiv_pkg::xlen-1:0]     result;
    muldiv_pkg::wb_t                 wb_q;
    logic                            done_q;

    always_comb begin
        a_signed = (s1.op == muldiv_pkg::mulh) || (s1.op == muldiv_pkg::mulhsu);
        b_signed = (s1.op == muldiv_pkg::mulh);
    end

    // Extending to 128 bits before an unsigned multiply gives the exact product
    // for every sign combination, since the true result always fits
    assign a_ext = {{muldiv_pkg::xlen{a_signed & s1.src1[muldiv_pkg::xlen-1]}}, s1.src1};
    assign b_ext = {{muldiv_pkg::xlen{b_signed & s1.src2[muldiv_pkg::xlen-1]}}, s1.src2};
    assign prod  = a_ext * b_ext;

    always_comb begin
        if (s1.op == muldiv_pkg::mul) begin
            if (s1.is_w) begin
                result = muldiv_pkg::sext_word(prod[muldiv_pkg::word_w-1:0]);
            end else begin
                result = prod[muldiv_pkg::xlen-1:0];
            end
        end else begin
            result = prod[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen]; // High half for mulh forms
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else if (adv) begin
            done_q <= go;
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            wb_q.result <= result;
            wb_q.nxtpc  <= s1.nxtpc;
            wb_q.rd     <= s1.rd;
            wb_q.error  <= s1.error;
        end
    end

    assign done = done_q;
    assign wb   = wb_q;

endmodule

/* rtl/muldiv_ctrl.sv */
module muldiv_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              block,
    input  logic                              valid_in,
    input  muldiv_pkg::issue_req_t            req,
    output logic                              ready,
    output logic                              adv,
    output muldiv_pkg::issue_req_t            s1,
    output logic                              mul_go,
    output logic                              div_go,
    input  logic                              mul_done,
    input  muldiv_pkg::wb_t                   mul_wb,
    input  logic                              div_done,
    input  muldiv_pkg::wb_t                   div_wb,
    output logic                              valid_part,
    output logic [muldiv_pkg::reg_addr_w-1:0] rd_part,
    output logic                              valid,
    output muldiv_pkg::wb_t                   wb
);

    muldiv_pkg::issue_req_t issue_q;
    logic                   issue_valid_q;
    logic                   is_div;

    // The whole unit moves as one, any block freezes every stage
    assign adv   = ~block;
    assign ready = ~block;

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid_q <= 1'b0;
        end else if (adv) begin
            issue_valid_q <= valid_in; // No request means a bubble enters stage 1
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            issue_q <= req;
        end
    end

    // Route stage 1 to exactly one datapath by operation class
    assign is_div = muldiv_pkg::op_is_div(issue_q.op);
    assign mul_go = issue_valid_q & ~is_div;
    assign div_go = issue_valid_q & is_div;

    assign s1 = issue_q;

    // Hazard view for the core, the destination still in flight in stage 1
    assign valid_part = issue_valid_q;
    assign rd_part    = issue_q.rd;

    // Equal latency in both datapaths keeps the done bits mutually exclusive
    always_comb begin
        valid = mul_done | div_done;
        if (div_done) begin
            wb = div_wb;
        end else begin
            wb = mul_wb;
        end
    end

endmodule

/* rtl/muldiv_pkg.sv */
package muldiv_pkg;

    localparam int xlen       = 64;
    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;

    // Top bit set marks the divide class, bit 1 picks remainder, bit 0 unsigned
    typedef enum logic [2:0] {
        mul    = 3'b000,
        mulh   = 3'b001,
        mulhsu = 3'b010,
        mulhu  = 3'b011,
        div    = 3'b100,
        divu   = 3'b101,
        rem    = 3'b110,
        remu   = 3'b111
    } muldiv_op_e;

    typedef struct packed {
        logic [xlen-1:0]       src1;
        logic [xlen-1:0]       src2;
        logic [xlen-1:0]       nxtpc;
        logic [reg_addr_w-1:0] rd;
        muldiv_op_e            op;
        logic                  is_w;  // Word form, operates on the low 32 bits
        logic                  error; // Error already raised upstream
    } issue_req_t;

    typedef struct packed {
        logic [xlen-1:0]       result;
        logic [xlen-1:0]       nxtpc;
        logic [reg_addr_w-1:0] rd;
        logic                  error;
    } wb_t;

    function automatic logic op_is_div(input muldiv_op_e op);
        return op[2];
    endfunction

    // Only meaningful for divide-class operations
    function automatic logic op_is_rem(input muldiv_op_e op);
        return op[1];
    endfunction

    function automatic logic op_is_unsigned_div(input muldiv_op_e op);
        return op[0];
    endfunction

    // Word results are always sign-extended to the full register width
    function automatic logic [xlen-1:0] sext_word(input logic [word_w-1:0] w);
        return {{(xlen - word_w){w[word_w-1]}}, w};
    endfunction

endpackage

/* rtl/muldiv_unit.sv */
module muldiv_unit (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              block,
    input  logic                              valid_in,
    input  muldiv_pkg::issue_req_t            req,
    output logic                              ready,
    output logic                              valid_part,
    output logic [muldiv_pkg::reg_addr_w-1:0] rd_part,
    output logic                              valid,
    output muldiv_pkg::wb_t                   wb
);

    logic                   adv;
    muldiv_pkg::issue_req_t s1;
    logic                   mul_go;
    logic                   div_go;
    logic                   mul_done;
    logic                   div_done;
    muldiv_pkg::wb_t        mul_wb;
    muldiv_pkg::wb_t        div_wb;

    muldiv_ctrl muldiv_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .block      (block),
        .valid_in   (valid_in),
        .req        (req),
        .ready      (ready),
        .adv        (adv),
        .s1         (s1),
        .mul_go     (mul_go),
        .div_go     (div_go),
        .mul_done   (mul_done),
        .mul_wb     (mul_wb),
        .div_done   (div_done),
        .div_wb     (div_wb),
        .valid_part (valid_part),
        .rd_part    (rd_part),
        .valid      (valid),
        .wb         (wb)
    );

    // Both datapaths see the same stage-1 payload, only the strobe differs
    mul_pipe mul_pipe_i (
        .clk  (clk),
        .rst  (rst),
        .adv  (adv),
        .go   (mul_go),
        .s1   (s1),
        .done (mul_done),
        .wb   (mul_wb)
    );

    div_pipe div_pipe_i (
        .clk  (clk),
        .rst  (rst),
        .adv  (adv),
        .go   (div_go),
        .s1   (s1),
        .done (div_done),
        .wb   (div_wb)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the simulation with Verilator, runs it and looks for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module muldiv_tb -f build.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vmuldiv_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* verification/muldiv_model.svh */
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

function automatic logic [63:0] sext32(input logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

// Operands widened by their own signedness, so the 128-bit product is exact
function automatic logic [63:0] mul_model(input muldiv_pkg::issue_req_t r);
    logic signed [129:0] a;
    logic signed [129:0] b;
    logic signed [129:0] p;
    a = $signed({66'd0, r.src1});
    b = $signed({66'd0, r.src2});
    if (r.op == muldiv_pkg::mulh || r.op == muldiv_pkg::mulhsu) begin
        a = $signed({{66{r.src1[63]}}, r.src1});
    end
    if (r.op == muldiv_pkg::mulh) begin
        b = $signed({{66{r.src2[63]}}, r.src2});
    end
    p = a * b;
    if (r.op != muldiv_pkg::mul) begin
        return p[127:64];
    end
    return r.is_w ? sext32(p[31:0]) : p[63:0];
endfunction

function automatic logic [63:0] div_model(input muldiv_pkg::issue_req_t r);
    logic        uns;
    logic        want_rem;
    logic [31:0] q32;
    logic [31:0] m32;
    logic [63:0] q64;
    logic [63:0] m64;
    int          sa32;
    int          sb32;
    longint      sa64;
    longint      sb64;
    uns      = (r.op == muldiv_pkg::divu) || (r.op == muldiv_pkg::remu);
    want_rem = (r.op == muldiv_pkg::rem) || (r.op == muldiv_pkg::remu);
    sa32 = r.src1[31:0];
    sb32 = r.src2[31:0];
    sa64 = r.src1;
    sb64 = r.src2;
    if (r.is_w) begin
        if (r.src2[31:0] == 32'd0) begin
            q32 = '1;
            m32 = r.src1[31:0];
        end else if (!uns && r.src1[31:0] == 32'h8000_0000 && r.src2[31:0] == '1) begin
            q32 = r.src1[31:0]; // Signed overflow keeps the dividend
            m32 = 32'd0;
        end else if (uns) begin
            q32 = r.src1[31:0] / r.src2[31:0];
            m32 = r.src1[31:0] % r.src2[31:0];
        end else begin
            q32 = sa32 / sb32;
            m32 = sa32 % sb32;
        end
        return sext32(want_rem ? m32 : q32);
    end
    if (r.src2 == 64'd0) begin
        q64 = '1;
        m64 = r.src1;
    end else if (!uns && r.src1 == {1'b1, 63'd0} && r.src2 == '1) begin
        q64 = r.src1;
        m64 = 64'd0;
    end else if (uns) begin
        q64 = r.src1 / r.src2;
        m64 = r.src1 % r.src2;
    end else begin
        q64 = sa64 / sb64;
        m64 = sa64 % sb64;
    end
    return want_rem ? m64 : q64;
endfunction

function automatic muldiv_pkg::wb_t expected_wb(input muldiv_pkg::issue_req_t r);
    muldiv_pkg::wb_t w;
    logic            div_class;
    logic            zero;
    div_class = r.op inside {muldiv_pkg::div, muldiv_pkg::divu, muldiv_pkg::rem, muldiv_pkg::remu};
    zero      = r.is_w ? (r.src2[31:0] == 32'd0) : (r.src2 == 64'd0);
    w.result  = div_class ? div_model(r) : mul_model(r);
    w.nxtpc   = r.nxtpc;
    w.rd      = r.rd;
    w.error   = r.error | (div_class & zero); // Only a divide by zero adds an error
    return w;
endfunction

`endif

/* verification/muldiv_tb.sv */
module muldiv_tb;

    `include "muldiv_model.svh"

    localparam int n_mix       = 400;
    localparam int n_lat       = 200;
    localparam int n_edge      = 16;
    localparam int n_stall     = 200;
    localparam int n_hzd       = 100;
    localparam int n_rst       = 41;
    localparam int total_reqs  = n_mix + n_lat + n_edge + n_stall + n_hzd + n_rst;
    localparam int cycle_limit = total_reqs * 4 + 100;

    logic                              clk;
    logic                              rst;
    logic                              block;
    logic                              valid_in;
    muldiv_pkg::issue_req_t            req;
    logic                              ready;
    logic                              valid_part;
    logic [muldiv_pkg::reg_addr_w-1:0] rd_part;
    logic                              valid;
    muldiv_pkg::wb_t                   wb;

    logic [31:0]                       rng_state;
    muldiv_pkg::wb_t                   exp_q[$];
    logic                              exp_valid;
    logic                              exp_part;
    logic [muldiv_pkg::reg_addr_w-1:0] exp_rd;
    logic                              stall_on;
    int                                errors;
    int                                checks;
    int                                test_errors;
    int                                tests;
    int                                cycles;

    muldiv_unit muldiv_unit_i (
        .clk        (clk),
        .rst        (rst),
        .block      (block),
        .valid_in   (valid_in),
        .req        (req),
        .ready      (ready),
        .valid_part (valid_part),
        .rd_part    (rd_part),
        .valid      (valid),
        .wb         (wb)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic muldiv_pkg::issue_req_t rand_req();
        muldiv_pkg::issue_req_t r;
        logic [31:0]            pick;
        r.src1  = {next_rand(), next_rand()};
        r.src2  = {next_rand(), next_rand()};
        r.nxtpc = {next_rand(), next_rand()};
        pick    = next_rand();
        r.rd    = pick[4:0];
        r.op    = muldiv_pkg::muldiv_op_e'(pick[7:5]);
        r.is_w  = pick[8];
        r.error = (pick[11:9] == 3'd0);
        // Zero and overflow operands show up now and then, not only in the directed test
        case (pick[14:12])
            3'd0: r.src2 = '0;
            3'd1: r.src2[31:0] = '0;
            3'd2: begin
                r.src1 = 64'h8000_0000_8000_0000;
                r.src2 = '1;
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic check_wb(input muldiv_pkg::wb_t got, input muldiv_pkg::wb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: wb result %h nxtpc %h rd %0d error %b", $time,
                     got.result, got.nxtpc, got.rd, got.error);
            $display("    expected result %h nxtpc %h rd %0d error %b",
                     exp.result, exp.nxtpc, exp.rd, exp.error);
        end
    endtask

    task automatic check_hazard(input logic got_v, input logic [muldiv_pkg::reg_addr_w-1:0] got_rd,
                                input logic exp_v, input logic [muldiv_pkg::reg_addr_w-1:0] exp_r);
        checks++;
        if (got_v !== exp_v || (exp_v && got_rd !== exp_r)) begin
            errors++;
            $display("ERR %0t: valid_part %b rd_part %0d, expected %b %0d", $time,
                     got_v, got_rd, exp_v, exp_r);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Outputs are stable at the falling edge and the coming rising edge decides what moves
    always @(negedge clk) begin
        check_flag("ready", ready, ~block);
        check_flag("valid", valid, exp_valid);
        check_hazard(valid_part, rd_part, exp_part, exp_rd);
        if (valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("A writeback appeared at time %0t with no request outstanding", $time);
            end else if (block) begin
                check_wb(wb, exp_q[0]); // A stalled result stays on the outputs until it moves on
            end else begin
                check_wb(wb, exp_q.pop_front());
            end
        end
        if (rst) begin
            exp_q.delete(); // In-flight work is dropped
            exp_valid = 1'b0;
            exp_part  = 1'b0;
        end else if (!block) begin
            exp_valid = exp_part;
            exp_part  = valid_in;
            exp_rd    = req.rd;
            if (valid_in) begin
                exp_q.push_back(expected_wb(req));
            end
        end
    end

    task automatic send(input muldiv_pkg::issue_req_t r);
        logic        taken;
        logic [31:0] roll;
        taken    = 1'b0;
        valid_in = 1'b1;
        req      = r;
        while (!taken) begin
            roll  = next_rand();
            block = stall_on && (roll % 10 < 3);
            @(posedge clk);
            taken = ready;
            #1;
        end
    endtask

    task automatic idle(input int n);
        valid_in = 1'b0;
        block    = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        valid_in = 1'b0;
        block    = 1'b0;
        while (exp_q.size() != 0 && waited < 8) begin
            idle(1);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results of %s were never written back", exp_q.size(), name);
            exp_q.delete();
        end
        idle(2);
        $display("%s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
        tests++;
    endtask

    initial begin
        muldiv_pkg::issue_req_t r;
        logic [31:0]            roll;
        rng_state    = 32'h848c_bf77;
        errors       = 0;
        checks       = 0;
        test_errors  = 0;
        tests        = 0;
        exp_valid    = 1'b0;
        exp_part     = 1'b0;
        exp_rd       = '0;
        stall_on     = 1'b0;
        rst          = 1'b1;
        block        = 1'b0;
        valid_in     = 1'b0;
        req          = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < n_mix; i++) begin
            send(rand_req());
        end
        finish_test("random_mix");

        for (int i = 0; i < n_lat; i++) begin
            send(rand_req());
        end
        finish_test("latency");

        // Bits of i pick the divide op, the word flag and zero versus overflow
        for (int i = 0; i < n_edge; i++) begin
            r       = rand_req();
            r.op    = muldiv_pkg::muldiv_op_e'({1'b1, i[1:0]});
            r.is_w  = i[2];
            r.error = 1'b0;
            if (i[3]) begin
                r.src1 = r.is_w ? {r.src1[63:32], 32'h8000_0000} : {1'b1, 63'd0};
                r.src2 = r.is_w ? {r.src2[63:32], 32'hffff_ffff} : '1;
            end else begin
                r.src2 = r.is_w ? {r.src2[63:32] | 32'd1, 32'd0} : '0;
            end
            send(r);
        end
        finish_test("div_edges");

        stall_on = 1'b1;
        for (int i = 0; i < n_stall; i++) begin
            send(rand_req());
        end
        stall_on = 1'b0;
        finish_test("stall");

        for (int i = 0; i < n_hzd; i++) begin
            roll = next_rand();
            if (roll[0]) begin
                idle(1);
            end
            send(rand_req());
        end
        finish_test("hazard");

        for (int i = 0; i < n_rst / 2; i++) begin
            send(rand_req());
        end
        valid_in = 1'b1;
        req      = rand_req();
        rst      = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        rst = 1'b0;
        for (int i = 0; i < n_rst - n_rst / 2; i++) begin
            send(rand_req());
        end
        finish_test("reset");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
